// ==== project.f ====
source/exu_pkg.sv
source/apb_issue.sv
source/uop_queue.sv
source/exec_unit.sv
source/result_file.sv
source/exu_top.sv
sim/tb_exu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then judge the log
rm -f sim.log
verilator --binary --timing --top-module tb_exu_top -f project.f -o tb_exu_top \
  && ./obj_dir/tb_exu_top > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "tests failed" sim.log \
  && { echo "FAIL"; exit 1; } \
  || { echo "PASS"; exit 0; }

// ==== sim/tb_exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exu_top import exu_pkg::*; ();

  localparam int XLEN   = 64;
  localparam int QDEPTH = 4;

  typedef struct packed {
    op_class_e       cls;
    logic [3:0]      op;
    logic [4:0]      rd;
    logic            we;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] jp1;
    logic [XLEN-1:0] jp2;
    logic [XLEN-1:0] exp_rd;
    logic            exp_jump;
    logic [XLEN-1:0] exp_jaddr;
    logic [4:0]      exp_ls;
    logic [XLEN-1:0] exp_store;
  } row_t;

  logic            clk;
  logic            rst_i;
  logic [11:0]     paddr;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [XLEN-1:0] pwdata;
  logic [XLEN-1:0] prdata;
  logic            pready;
  logic            pslverr;

  row_t            rows [$];
  logic [XLEN-1:0] shadow [32];
  logic [4:0]      shadow_ls;
  logic [XLEN-1:0] shadow_store;
  logic [15:0]     lfsr = 16'd34;
  int              data_errs = 0;
  int              flag_errs = 0;
  int              size_errs = 0;
  int              cycles = 0;
  int              cycle_limit = 0;

  exu_top #(
    .XLEN   (XLEN),
    .QDEPTH (QDEPTH)
  ) exu_top_inst (
    .clk       (clk),
    .rst_i     (rst_i),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  // taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [XLEN-1:0] w);
    w = '0;
    for (int i = 0; i < XLEN; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[XLEN-2:0], lfsr[0]};
    end
  endtask

  // reference behavior per the RISC-V integer spec
  function automatic logic [XLEN-1:0] model_alu(input alu_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      SLL:     return a << b[5:0];
      SLT:     return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      SLTU:    return {{(XLEN-1){1'b0}}, a < b};
      XOR:     return a ^ b;
      SRL:     return a >> b[5:0];
      SRA:     return $signed(a) >>> b[5:0];
      OR:      return a | b;
      AND:     return a & b;
      LUI:     return b;
      default: return '0;
    endcase
  endfunction

  function automatic logic model_taken(input bjp_op_e op,
                                       input logic [XLEN-1:0] a,
                                       input logic [XLEN-1:0] b);
    case (op)
      BEQ:     return a == b;
      BNE:     return a != b;
      BLT:     return $signed(a) < $signed(b);
      BGE:     return $signed(a) >= $signed(b);
      BLTU:    return a < b;
      BGEU:    return a >= b;
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] cmd_word(input op_class_e cls, input logic [3:0] op,
                                               input logic [4:0] rd, input logic we);
    logic [XLEN-1:0] w;
    w        = '0;
    w[1:0]   = cls;
    w[5:2]   = op;
    w[10:6]  = rd;
    w[11]    = we;
    return w;
  endfunction

  function automatic logic [11:0] rf_addr(input logic [4:0] n);
    return ADDR_RF_BASE + 12'(8 * n);
  endfunction

  // appends one row, expected values follow the shadow state
  task automatic add_row(input op_class_e cls, input logic [3:0] op, input logic [4:0] rd,
                         input logic we, input logic [XLEN-1:0] op1,
                         input logic [XLEN-1:0] op2, input logic [XLEN-1:0] jp1,
                         input logic [XLEN-1:0] jp2);
    row_t            r;
    logic            writes;
    logic [XLEN-1:0] value;
    r          = '0;
    r.cls      = cls;
    r.op       = op;
    r.rd       = rd;
    r.we       = we;
    r.op1      = op1;
    r.op2      = op2;
    r.jp1      = jp1;
    r.jp2      = jp2;
    writes     = 1'b0;
    value      = '0;
    case (cls)
      CLS_ALU: begin
        value  = model_alu(alu_op_e'(op), op1, op2);
        writes = 1'b1;
      end
      CLS_BJP: begin
        r.exp_jump = model_taken(bjp_op_e'(op), op1, op2);
        value      = op1 + op2;
        writes     = (op == JAL) || (op == JALR);
      end
      default: begin
        shadow_ls    = {1'b1, op[1:0], op[2], op[3]};
        shadow_store = op[3] ? jp2 : '0;
      end
    endcase
    if (writes && we && rd != 5'd0) begin
      shadow[rd] = value;
    end
    r.exp_rd    = shadow[rd];
    r.exp_jaddr = jp1 + jp2;
    r.exp_ls    = shadow_ls;
    r.exp_store = shadow_store;
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] j1;
    logic [XLEN-1:0] j2;
    logic [XLEN-1:0] pa [3];
    logic [XLEN-1:0] pb [3];
    int              rd;
    rd    = 1;
    // equal, less signed only, less unsigned only
    pa[0] = 64'h0000_0000_0000_1234;
    pb[0] = 64'h0000_0000_0000_1234;
    pa[1] = 64'hffff_ffff_ffff_ffff;
    pb[1] = 64'h0000_0000_0000_0001;
    pa[2] = 64'h0000_0000_0000_0001;
    pb[2] = 64'hffff_ffff_ffff_ffff;
    for (int op = 0; op <= 10; op++) begin
      add_row(CLS_ALU, 4'(op), 5'(rd), 1'b1, 64'h8000_0000_0000_0001,
              64'h0000_0000_0000_003f, '0, '0);
      rd = (rd % 31) + 1;
      add_row(CLS_ALU, 4'(op), 5'(rd), 1'b1, 64'h7fff_ffff_ffff_ffff,
              64'hffff_ffff_ffff_ffff, '0, '0);
      rd = (rd % 31) + 1;
      rand_word(a);
      rand_word(b);
      add_row(CLS_ALU, 4'(op), 5'(rd), 1'b1, a, b, '0, '0);
      rd = (rd % 31) + 1;
    end
    for (int op = 0; op <= 7; op++) begin
      for (int p = 0; p < 3; p++) begin
        rand_word(j1);
        rand_word(j2);
        add_row(CLS_BJP, 4'(op), 5'(rd), 1'b1, pa[p], pb[p], j1, j2);
        rd = (rd % 31) + 1;
      end
    end
    // rd is set but must keep its earlier value
    for (int k = 0; k < 16; k++) begin
      rand_word(a);
      rand_word(b);
      rand_word(j2);
      add_row(CLS_LS, 4'(k), 5'(k + 1), 1'b1, a, b, 64'h0, j2);
    end
    add_row(CLS_ALU, ADD, 5'd0, 1'b1, 64'd5, 64'd7, '0, '0);
    rand_word(a);
    rand_word(b);
    add_row(CLS_ALU, XOR, 5'd9, 1'b0, a, b, '0, '0);
  endtask

  task automatic compare_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      data_errs++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic compare_size(input string name, input ls_size_e got, input ls_size_e exp);
    if (got !== exp) begin
      size_errs++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // starts at a drive point, returns one drive point after completion
  task automatic apb_xfer(input logic wr, input logic [11:0] addr,
                          input logic [XLEN-1:0] wdata,
                          output logic [XLEN-1:0] rdata, output logic err,
                          output logic ready_first);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    ready_first = pready;
    while (!pready) begin
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [XLEN-1:0] data);
    logic [XLEN-1:0] unused_rd;
    logic            err;
    logic            rdy;
    apb_xfer(1'b1, addr, data, unused_rd, err, rdy);
    compare_flag($sformatf("pslverr wr %h", addr), err, 1'b0);
    // only a cmd write may wait for queue space
    if (addr != ADDR_CMD) begin
      compare_flag($sformatf("pready wr %h", addr), rdy, 1'b1);
    end
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [XLEN-1:0] data);
    logic err;
    logic rdy;
    apb_xfer(1'b0, addr, '0, data, err, rdy);
    compare_flag($sformatf("pslverr rd %h", addr), err, 1'b0);
    compare_flag($sformatf("pready rd %h", addr), rdy, 1'b1);
  endtask

  task automatic wait_idle();
    logic [XLEN-1:0] d;
    d = '0;
    while (!d[0]) begin
      apb_read(ADDR_STATUS, d);
    end
  endtask

  task automatic check_row(input int idx, input row_t r);
    logic [XLEN-1:0] d;
    apb_read(rf_addr(r.rd), d);
    compare_data($sformatf("row %0d x%0d", idx, r.rd), d, r.exp_rd);
    apb_read(ADDR_STATUS, d);
    compare_flag($sformatf("row %0d status.bad_op", idx), d[9], 1'b0);
    if (r.cls == CLS_BJP) begin
      compare_flag($sformatf("row %0d status.jump", idx), d[8], r.exp_jump);
      apb_read(ADDR_JUMP, d);
      compare_data($sformatf("row %0d jump_addr", idx), d, r.exp_jaddr);
    end
    apb_read(ADDR_LS, d);
    compare_flag($sformatf("row %0d ls.store", idx), d[0], r.exp_ls[0]);
    compare_flag($sformatf("row %0d ls.unsigned", idx), d[1], r.exp_ls[1]);
    compare_size($sformatf("row %0d ls.size", idx), ls_size_e'(d[3:2]),
                 ls_size_e'(r.exp_ls[3:2]));
    compare_flag($sformatf("row %0d ls.valid", idx), d[4], r.exp_ls[4]);
    apb_read(ADDR_STORE, d);
    compare_data($sformatf("row %0d store_data", idx), d, r.exp_store);
  endtask

  initial begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] d;
    logic            err;
    logic            rdy;
    alu_op_e         bop;
    logic [4:0]      brd;
    rst_i        = 1'b1;
    paddr        = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = '0;
    shadow       = '{default: '0};
    shadow_ls    = '0;
    shadow_store = '0;
    build_table();
    cycle_limit = rows.size() * 40 + 200;
    repeat (4) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // state right after reset
    apb_read(ADDR_STATUS, d);
    compare_flag("status.idle", d[0], 1'b1);
    compare_flag("status.jump", d[8], 1'b0);
    compare_flag("status.bad_op", d[9], 1'b0);

    foreach (rows[i]) begin
      apb_write(ADDR_OP1, rows[i].op1);
      apb_write(ADDR_OP2, rows[i].op2);
      apb_write(ADDR_JP1, rows[i].jp1);
      apb_write(ADDR_JP2, rows[i].jp2);
      apb_write(ADDR_CMD, cmd_word(rows[i].cls, rows[i].op, rows[i].rd, rows[i].we));
      wait_idle();
      check_row(i, rows[i]);
    end

    // back-to-back commands on one operand pair, the last one reuses x20
    rand_word(a);
    rand_word(b);
    apb_write(ADDR_OP1, a);
    apb_write(ADDR_OP2, b);
    for (int k = 0; k < QDEPTH + 2; k++) begin
      bop = alu_op_e'(4'(k % 11));
      brd = 5'(20 + k % (QDEPTH + 1));
      apb_write(ADDR_CMD, cmd_word(CLS_ALU, bop, brd, 1'b1));
      shadow[brd] = model_alu(bop, a, b);
    end
    wait_idle();
    for (int k = 0; k <= QDEPTH; k++) begin
      apb_read(rf_addr(5'(20 + k)), d);
      compare_data($sformatf("burst x%0d", 20 + k), d, shadow[5'(20 + k)]);
    end

    // unknown opcode is sticky and writes nothing
    apb_write(ADDR_CMD, cmd_word(CLS_ALU, 4'd12, 5'd3, 1'b1));
    wait_idle();
    apb_read(ADDR_STATUS, d);
    compare_flag("status.bad_op", d[9], 1'b1);
    apb_read(rf_addr(5'd3), d);
    compare_data("x3", d, shadow[3]);

    apb_xfer(1'b0, 12'h048, '0, d, err, rdy);
    compare_flag("pslverr unmapped 048", err, 1'b1);
    compare_flag("pready unmapped 048", rdy, 1'b1);
    apb_xfer(1'b0, 12'h104, '0, d, err, rdy);
    compare_flag("pslverr unaligned 104", err, 1'b1);
    compare_flag("pready unaligned 104", rdy, 1'b1);
    apb_xfer(1'b1, ADDR_STATUS, '0, d, err, rdy);
    compare_flag("pslverr write status", err, 1'b1);
    compare_flag("pready write status", rdy, 1'b1);
    apb_read(ADDR_STATUS, d);
    compare_flag("status.bad_op", d[9], 1'b1);

    $display("errors: data %0d, flag %0d, size %0d", data_errs, flag_errs, size_errs);
    if (data_errs + flag_errs + size_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/apb_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_issue import exu_pkg::*; #(
  parameter int XLEN   = 64,
  parameter int QDEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic [11:0]                 paddr_i,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [XLEN-1:0]             pwdata_i,
  output logic [XLEN-1:0]             prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  input  logic                        full_i,
  input  logic [$clog2(QDEPTH+1)-1:0] count_i,
  input  logic                        busy_i,
  output logic [4:0]                  rf_idx_o,
  input  logic [XLEN-1:0]             rf_rdata_i,
  input  exu_res_t                    stat_i,
  input  logic                        bad_op_i,
  output logic                        push_o,
  output uop_t                        push_uop_o
);

  logic [XLEN-1:0] op1_q;
  logic [XLEN-1:0] op2_q;
  logic [XLEN-1:0] jp1_q;
  logic [XLEN-1:0] jp2_q;
  logic            access;
  logic            wr;
  logic            is_cmd;
  logic            is_rf;
  logic            hit_rw;
  logic            hit_ro;
  logic [XLEN-1:0] status_w;
  logic [XLEN-1:0] ls_w;
  logic [XLEN-1:0] rd_mux;

  assign access   = psel_i && penable_i;
  assign wr       = access && pwrite_i;
  assign is_cmd   = (paddr_i == ADDR_CMD);
  // register file window 0x100..0x1f8, dword aligned
  assign is_rf    = (paddr_i[11:8] == ADDR_RF_BASE[11:8]) && (paddr_i[2:0] == 3'b000);
  assign rf_idx_o = paddr_i[7:3];

  always_comb begin
    status_w      = '0;
    status_w[0]   = (count_i == '0) && !busy_i;
    status_w[7:4] = 4'(count_i);
    status_w[8]   = stat_i.jump_flag;
    status_w[9]   = bad_op_i;
    ls_w          = '0;
    ls_w[0]       = stat_i.ls_store;
    ls_w[1]       = stat_i.ls_unsigned;
    ls_w[3:2]     = stat_i.ls_size;
    ls_w[4]       = stat_i.ls_valid;
  end

  // address decode and read mux
  always_comb begin
    hit_rw = 1'b1;
    hit_ro = 1'b0;
    rd_mux = '0;
    case (paddr_i)
      ADDR_OP1: rd_mux = op1_q;
      ADDR_OP2: rd_mux = op2_q;
      ADDR_JP1: rd_mux = jp1_q;
      ADDR_JP2: rd_mux = jp2_q;
      // cmd is write only, reads return zero
      ADDR_CMD: rd_mux = '0;
      ADDR_STATUS: begin
        hit_rw = 1'b0;
        hit_ro = 1'b1;
        rd_mux = status_w;
      end
      ADDR_JUMP: begin
        hit_rw = 1'b0;
        hit_ro = 1'b1;
        rd_mux = stat_i.jump_addr;
      end
      ADDR_LS: begin
        hit_rw = 1'b0;
        hit_ro = 1'b1;
        rd_mux = ls_w;
      end
      ADDR_STORE: begin
        hit_rw = 1'b0;
        hit_ro = 1'b1;
        rd_mux = stat_i.store_data;
      end
      default: begin
        hit_rw = 1'b0;
        hit_ro = is_rf;
        rd_mux = is_rf ? rf_rdata_i : '0;
      end
    endcase
  end

  assign prdata_o  = rd_mux;
  // wait states only for a cmd write into a full queue
  assign pready_o  = !(wr && is_cmd && full_i);
  assign pslverr_o = access && (!(hit_rw || hit_ro) || (pwrite_i && hit_ro));
  assign push_o    = wr && is_cmd && !full_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      op1_q <= '0;
      op2_q <= '0;
      jp1_q <= '0;
      jp2_q <= '0;
    end else if (wr) begin
      case (paddr_i)
        ADDR_OP1: op1_q <= pwdata_i;
        ADDR_OP2: op2_q <= pwdata_i;
        ADDR_JP1: jp1_q <= pwdata_i;
        ADDR_JP2: jp2_q <= pwdata_i;
        default: begin
        end
      endcase
    end
  end

  // micro-op from the cmd word plus staged operands
  always_comb begin
    push_uop_o.op_class = op_class_e'(pwdata_i[1:0]);
    push_uop_o.op       = pwdata_i[5:2];
    push_uop_o.rd_idx   = pwdata_i[10:6];
    push_uop_o.rd_we    = pwdata_i[11];
    push_uop_o.op1      = op1_q;
    push_uop_o.op2      = op2_q;
    push_uop_o.jp1      = jp1_q;
    push_uop_o.jp2      = jp2_q;
  end

endmodule

`default_nettype wire

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit import exu_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic     clk,
  input  logic     rst_i,
  input  logic     head_valid_i,
  input  uop_t     head_uop_i,
  output logic     pop_o,
  output logic     busy_o,
  output exu_res_t res_o
);

  localparam int SHW = $clog2(XLEN);

  uop_t            u;
  alu_op_e         alu_op;
  bjp_op_e         bjp_op;
  logic            alu_req;
  logic            bjp_req;
  logic            is_jump;
  logic            use_sub;
  logic [XLEN-1:0] add_in2;
  logic [XLEN:0]   add_sum;
  logic [SHW-1:0]  shamt;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] alu_res;
  logic            alu_ok;
  logic            bjp_ok;
  logic            taken;
  exu_res_t        res_d;
  exu_res_t        res_q;

  assign u       = head_uop_i;
  assign alu_op  = alu_op_e'(u.op);
  assign bjp_op  = bjp_op_e'(u.op);
  assign alu_req = (u.op_class == CLS_ALU);
  assign bjp_req = (u.op_class == CLS_BJP);
  assign is_jump = bjp_req && (bjp_op inside {JAL, JALR});

  // one adder, subtracts for compares and conditional branches
  assign use_sub = (alu_req && (alu_op inside {SUB, SLT, SLTU})) || (bjp_req && !is_jump);
  assign add_in2 = use_sub ? ~u.op2 : u.op2;
  assign add_sum = {1'b0, u.op1} + {1'b0, add_in2} + {{XLEN{1'b0}}, use_sub};

  assign eq   = (add_sum[XLEN-1:0] == '0);
  // no carry out of op1 + ~op2 + 1 means op1 < op2 unsigned
  assign lt_u = !add_sum[XLEN];
  assign lt_s = (u.op1[XLEN-1] && !u.op2[XLEN-1]) ||
                (!(u.op1[XLEN-1] ^ u.op2[XLEN-1]) && add_sum[XLEN-1]);

  assign shamt = u.op2[SHW-1:0];

  always_comb begin
    alu_ok = 1'b1;
    case (alu_op)
      ADD, SUB: alu_res = add_sum[XLEN-1:0];
      SLL:      alu_res = u.op1 << shamt;
      SLT:      alu_res = {{(XLEN-1){1'b0}}, lt_s};
      SLTU:     alu_res = {{(XLEN-1){1'b0}}, lt_u};
      XOR:      alu_res = u.op1 ^ u.op2;
      SRL:      alu_res = u.op1 >> shamt;
      SRA:      alu_res = $signed(u.op1) >>> shamt;
      OR:       alu_res = u.op1 | u.op2;
      AND:      alu_res = u.op1 & u.op2;
      LUI:      alu_res = u.op2;
      default: begin
        alu_res = '0;
        alu_ok  = 1'b0;
      end
    endcase
  end

  always_comb begin
    bjp_ok = 1'b1;
    taken  = 1'b0;
    case (bjp_op)
      JAL, JALR: taken = 1'b1;
      BEQ:       taken = eq;
      BNE:       taken = !eq;
      BLT:       taken = lt_s;
      BGE:       taken = !lt_s;
      BLTU:      taken = lt_u;
      BGEU:      taken = !lt_u;
      default:   bjp_ok = 1'b0;
    endcase
  end

  always_comb begin
    res_d           = '0;
    res_d.valid     = 1'b1;
    res_d.rd_idx    = u.rd_idx;
    res_d.jump_addr = u.jp1 + u.jp2;
    case (u.op_class)
      CLS_ALU: begin
        res_d.res    = alu_res;
        res_d.bad_op = !alu_ok;
      end
      CLS_BJP: begin
        // link value for jal and jalr
        res_d.res       = add_sum[XLEN-1:0];
        res_d.jump_flag = taken && bjp_ok;
        res_d.bad_op    = !bjp_ok;
      end
      CLS_LS: begin
        res_d.res         = add_sum[XLEN-1:0];
        res_d.ls_valid    = 1'b1;
        res_d.ls_store    = u.op[3];
        res_d.ls_unsigned = u.op[2];
        res_d.ls_size     = ls_size_e'(u.op[1:0]);
        res_d.store_data  = u.op[3] ? u.jp2 : '0;
      end
      default: res_d.bad_op = 1'b1;
    endcase
    // loads and stores never write rd, x0 stays zero
    res_d.rd_we = u.rd_we && (u.rd_idx != 5'd0) && !res_d.bad_op && (alu_req || is_jump);
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      res_q <= '0;
    end else if (head_valid_i) begin
      res_q <= res_d;
    end else begin
      res_q.valid <= 1'b0;
    end
  end

  // head is consumed every cycle it is valid
  assign pop_o  = head_valid_i;
  assign busy_o = res_q.valid;
  assign res_o  = res_q;

endmodule

`default_nettype wire

// ==== source/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  // width of the struct fields below
  localparam int PKG_XLEN = 64;

  typedef enum logic [1:0] {
    CLS_ALU = 2'd0,
    CLS_BJP = 2'd1,
    CLS_LS  = 2'd2
  } op_class_e;

  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    SLL  = 4'd2,
    SLT  = 4'd3,
    SLTU = 4'd4,
    XOR  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    OR   = 4'd8,
    AND  = 4'd9,
    LUI  = 4'd10
  } alu_op_e;

  typedef enum logic [3:0] {
    JAL  = 4'd0,
    JALR = 4'd1,
    BEQ  = 4'd2,
    BNE  = 4'd3,
    BLT  = 4'd4,
    BGE  = 4'd5,
    BLTU = 4'd6,
    BGEU = 4'd7
  } bjp_op_e;

  typedef enum logic [1:0] {
    LS_BYTE  = 2'd0,
    LS_HALF  = 2'd1,
    LS_WORD  = 2'd2,
    LS_DWORD = 2'd3
  } ls_size_e;

  // ls ops use op[3] store, op[2] unsigned, op[1:0] size
  typedef struct packed {
    op_class_e             op_class;
    logic [3:0]            op;
    logic [4:0]            rd_idx;
    logic                  rd_we;
    logic [PKG_XLEN-1:0]   op1;
    logic [PKG_XLEN-1:0]   op2;
    logic [PKG_XLEN-1:0]   jp1;
    logic [PKG_XLEN-1:0]   jp2;
  } uop_t;

  typedef struct packed {
    logic                  valid;
    logic                  rd_we;
    logic [4:0]            rd_idx;
    logic [PKG_XLEN-1:0]   res;
    logic                  jump_flag;
    logic [PKG_XLEN-1:0]   jump_addr;
    logic                  ls_valid;
    logic                  ls_store;
    logic                  ls_unsigned;
    ls_size_e              ls_size;
    logic [PKG_XLEN-1:0]   store_data;
    logic                  bad_op;
  } exu_res_t;

  // apb register map, byte addresses
  localparam logic [11:0] ADDR_OP1     = 12'h000;
  localparam logic [11:0] ADDR_OP2     = 12'h008;
  localparam logic [11:0] ADDR_JP1     = 12'h010;
  localparam logic [11:0] ADDR_JP2     = 12'h018;
  localparam logic [11:0] ADDR_CMD     = 12'h020;
  localparam logic [11:0] ADDR_STATUS  = 12'h028;
  localparam logic [11:0] ADDR_JUMP    = 12'h030;
  localparam logic [11:0] ADDR_LS      = 12'h038;
  localparam logic [11:0] ADDR_STORE   = 12'h040;
  localparam logic [11:0] ADDR_RF_BASE = 12'h100;

endpackage

`default_nettype wire

// ==== source/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exu_top import exu_pkg::*; #(
  parameter int XLEN   = 64,
  parameter int QDEPTH = 4
) (
  input  logic            clk,
  input  logic            rst_i,
  input  logic [11:0]     paddr_i,
  input  logic            psel_i,
  input  logic            penable_i,
  input  logic            pwrite_i,
  input  logic [XLEN-1:0] pwdata_i,
  output logic [XLEN-1:0] prdata_o,
  output logic            pready_o,
  output logic            pslverr_o
);

  logic                        push;
  uop_t                        push_uop;
  logic                        full;
  logic [$clog2(QDEPTH+1)-1:0] count;
  logic                        pop;
  logic                        head_valid;
  uop_t                        head_uop;
  logic                        busy;
  exu_res_t                    res;
  logic [4:0]                  rf_idx;
  logic [XLEN-1:0]             rf_rdata;
  exu_res_t                    stat;
  logic                        bad_op;

  apb_issue #(
    .XLEN   (XLEN),
    .QDEPTH (QDEPTH)
  ) apb_issue_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .full_i     (full),
    .count_i    (count),
    .busy_i     (busy),
    .rf_idx_o   (rf_idx),
    .rf_rdata_i (rf_rdata),
    .stat_i     (stat),
    .bad_op_i   (bad_op),
    .push_o     (push),
    .push_uop_o (push_uop)
  );

  uop_queue #(
    .XLEN   (XLEN),
    .QDEPTH (QDEPTH)
  ) uop_queue_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .push_i       (push),
    .push_uop_i   (push_uop),
    .full_o       (full),
    .count_o      (count),
    .pop_i        (pop),
    .head_valid_o (head_valid),
    .head_uop_o   (head_uop)
  );

  exec_unit #(
    .XLEN (XLEN)
  ) exec_unit_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .head_valid_i (head_valid),
    .head_uop_i   (head_uop),
    .pop_o        (pop),
    .busy_o       (busy),
    .res_o        (res)
  );

  result_file #(
    .XLEN (XLEN)
  ) result_file_inst (
    .clk      (clk),
    .rst_i    (rst_i),
    .res_i    (res),
    .rd_idx_i (rf_idx),
    .rdata_o  (rf_rdata),
    .stat_o   (stat),
    .bad_op_o (bad_op)
  );

endmodule

`default_nettype wire

// ==== source/result_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_file import exu_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            rst_i,
  input  exu_res_t        res_i,
  input  logic [4:0]      rd_idx_i,
  output logic [XLEN-1:0] rdata_o,
  output exu_res_t        stat_o,
  output logic            bad_op_o
);

  logic [XLEN-1:0] regs [32];
  exu_res_t        stat_d;
  exu_res_t        stat_q;
  logic            bad_q;

  // ls info only moves on a load or store
  always_comb begin
    stat_d = res_i;
    if (!res_i.ls_valid) begin
      stat_d.ls_valid    = stat_q.ls_valid;
      stat_d.ls_store    = stat_q.ls_store;
      stat_d.ls_unsigned = stat_q.ls_unsigned;
      stat_d.ls_size     = stat_q.ls_size;
      stat_d.store_data  = stat_q.store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      stat_q <= '0;
      bad_q  <= 1'b0;
    end else if (res_i.valid) begin
      if (res_i.rd_we && (res_i.rd_idx != 5'd0)) begin
        regs[res_i.rd_idx] <= res_i.res;
      end
      stat_q <= stat_d;
      // sticky until reset
      bad_q  <= bad_q | res_i.bad_op;
    end
  end

  assign rdata_o  = regs[rd_idx_i];
  assign stat_o   = stat_q;
  assign bad_op_o = bad_q;

endmodule

`default_nettype wire

// ==== source/uop_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module uop_queue import exu_pkg::*; #(
  parameter int XLEN   = 64,
  parameter int QDEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        push_i,
  input  uop_t                        push_uop_i,
  output logic                        full_o,
  output logic [$clog2(QDEPTH+1)-1:0] count_o,
  input  logic                        pop_i,
  output logic                        head_valid_o,
  output uop_t                        head_uop_o
);

  localparam int PW = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CW = $clog2(QDEPTH+1);

  uop_t          mem [QDEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  // struct layout is fixed by the package width
  if (XLEN != PKG_XLEN) begin : g_xlen_check
    $error("uop_queue: XLEN does not match the micro-op struct width");
  end

  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
    return (p == PW'(QDEPTH-1)) ? '0 : p + 1'b1;
  endfunction

  assign do_pop       = pop_i && head_valid_o;
  // a pop in the same cycle makes room when full
  assign do_push      = push_i && (!full_o || do_pop);
  assign full_o       = (count_q == CW'(QDEPTH));
  assign head_valid_o = (count_q != '0);
  assign head_uop_o   = mem[rd_ptr];
  assign count_o      = count_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_uop_i;
    end
  end

endmodule

`default_nettype wire
